//--- src.f
src/agen_pkg.sv
src/agen_regfile.sv
src/agen_decode.sv
src/agen_execute.sv
src/agen_result.sv
src/agen_top.sv
testbench/agen_assertions.sv
testbench/agen_checker.sv
testbench/tb_agen.sv

//--- src/agen_decode.sv
`timescale 1ns/1ns

module agen_decode (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   wb_cyc,
   input  logic                   wb_stb,
   input  logic                   wb_we,
   input  agen_pkg::agen_uop_t    wb_dat_w,
   output logic                   wb_ack,
   output logic [2:0]             gpr_ra0,
   output logic [2:0]             gpr_ra1,
   output logic [2:0]             gpr_ra2,
   input  logic [31:0]            gpr_rd0,
   input  logic [31:0]            gpr_rd1,
   input  logic [31:0]            gpr_rd2,
   output logic [2:0]             seg_ra,
   input  logic [15:0]            seg_rd,
   input  agen_pkg::agen_result_t exe_busy_dest,
   input  agen_pkg::agen_result_t res_busy_dest,
   output logic                   issue_valid,
   output agen_pkg::agen_issue_t  issue
);
   import agen_pkg::*;

   agen_wr_t own_wr;
   logic     wb_req;
   logic     hazard;
   logic     accept;

   // True when a pending write to id is a source of uop u
   function automatic logic src_hit(agen_uop_t u, logic gpr_we, logic seg_we,
                                    logic [2:0] id);
      logic is_lea;
      logic is_push;
      logic gpr_hit;
      logic seg_hit;
      is_lea  = (u.opcode == op_lea);
      is_push = (u.opcode == op_push);
      gpr_hit = (is_lea && u.base_en && (u.base_id == id)) ||
                (is_lea && u.index_en && (u.index_id == id)) ||
                (is_push && (id == sp_id));
      seg_hit = (is_lea || is_push) && (u.seg_id == id);
      return (gpr_we && gpr_hit) || (seg_we && seg_hit);
   endfunction

   // Base, index, stack pointer and segment are read straight off the bus
   assign gpr_ra0 = wb_dat_w.base_id;
   assign gpr_ra1 = wb_dat_w.index_id;
   assign gpr_ra2 = sp_id;
   assign seg_ra  = wb_dat_w.seg_id;

   assign own_wr = agen_wr_target(issue.opcode, issue.dest);

   // No forwarding, so any in-flight writer of a source stalls the bus
   always_comb begin
      hazard = (issue_valid &&
                src_hit(wb_dat_w, own_wr.gpr_we, own_wr.seg_we, own_wr.id)) ||
               src_hit(wb_dat_w, exe_busy_dest.gpr_we, exe_busy_dest.seg_we,
                       exe_busy_dest.dest) ||
               src_hit(wb_dat_w, res_busy_dest.gpr_we, res_busy_dest.seg_we,
                       res_busy_dest.dest);
   end

   assign wb_req = wb_cyc && wb_stb && wb_we && !wb_ack;
   assign accept = wb_req && !hazard;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wb_ack      <= 1'b0;
         issue_valid <= 1'b0;
      end else begin
         wb_ack      <= accept;
         issue_valid <= accept;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         issue.opcode     <= wb_dat_w.opcode;
         issue.dest       <= wb_dat_w.dest;
         issue.base_en    <= wb_dat_w.base_en;
         issue.index_en   <= wb_dat_w.index_en;
         issue.disp_en    <= wb_dat_w.disp_en;
         issue.scale      <= wb_dat_w.scale;
         issue.mem_size   <= wb_dat_w.mem_size;
         issue.eip        <= wb_dat_w.eip;
         issue.imm        <= wb_dat_w.imm;
         issue.sel        <= wb_dat_w.sel;
         issue.nmi_en     <= wb_dat_w.nmi_en;
         issue.pf_en      <= wb_dat_w.pf_en;
         issue.gp_en      <= wb_dat_w.gp_en;
         issue.base_data  <= gpr_rd0;
         issue.index_data <= gpr_rd1;
         issue.sp_data    <= gpr_rd2;
         issue.seg_data   <= seg_rd;
      end
   end

endmodule

//--- src/agen_execute.sv
`timescale 1ns/1ns

module agen_execute (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   issue_valid,
   input  agen_pkg::agen_issue_t  issue,
   output logic                   exe_valid,
   output agen_pkg::agen_result_t exe
);
   import agen_pkg::*;

   agen_wr_t     wr;
   logic [31:0]  scaled;
   logic [31:0]  offset;
   logic [3:0]   push_size;
   logic [31:0]  new_sp;
   logic [31:0]  vector;
   agen_result_t nxt;

   function automatic logic [31:0] seg_linear(logic [15:0] seg, logic [31:0] off);
      return ({16'd0, seg} << seg_shift) + off;
   endfunction

   always_comb begin
      scaled = issue.index_data << issue.scale;
      offset = (issue.disp_en  ? issue.imm       : 32'd0) +
               (issue.base_en  ? issue.base_data : 32'd0) +
               (issue.index_en ? scaled          : 32'd0);

      case (issue.mem_size)
         2'd0:    push_size = 4'd2;
         2'd1:    push_size = 4'd4;
         default: push_size = 4'd8;
      endcase
      new_sp = issue.sp_data - {28'd0, push_size};

      // NMI wins over page fault, page fault over general protection
      if (issue.nmi_en) begin
         vector = vec_nmi;
      end else if (issue.pf_en) begin
         vector = vec_page_fault;
      end else if (issue.gp_en) begin
         vector = vec_gen_prot;
      end else begin
         vector = vec_none;
      end

      wr = agen_wr_target(issue.opcode, issue.dest);

      nxt          = '0;
      nxt.opcode   = issue.opcode;
      nxt.gpr_we   = issue_valid && wr.gpr_we;
      nxt.seg_we   = issue_valid && wr.seg_we;
      nxt.dest     = wr.id;
      nxt.next_eip = issue.eip;

      case (issue.opcode)
         op_mov_gpr: nxt.value = issue.imm;
         op_mov_seg: nxt.value = {16'd0, issue.imm[15:0]};
         op_lea: begin
            nxt.value    = offset;
            nxt.lin_addr = seg_linear(issue.seg_data, offset);
         end
         op_push: begin
            nxt.value    = new_sp;
            nxt.lin_addr = seg_linear(issue.seg_data, new_sp);
         end
         op_jmp_rel: nxt.next_eip = issue.eip + issue.imm;
         op_jmp_far: begin
            nxt.next_eip = issue.imm;
            nxt.next_cs  = issue.sel;
         end
         // Vector goes out as both value and address
         op_int: begin
            nxt.value    = vector;
            nxt.lin_addr = vector;
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         exe_valid <= 1'b0;
         exe       <= '0;
      end else begin
         exe_valid <= issue_valid;
         exe       <= nxt;
      end
   end

endmodule

//--- src/agen_pkg.sv
package agen_pkg;

   localparam int          num_regs   = 8;
   localparam logic [2:0]  sp_id      = 3'd4;
   localparam int          seg_shift  = 16;

   // IDT entry addresses, eight bytes per gate
   localparam logic [31:0] vec_nmi        = 32'h0000_0010;
   localparam logic [31:0] vec_page_fault = 32'h0000_0070;
   localparam logic [31:0] vec_gen_prot   = 32'h0000_0068;
   localparam logic [31:0] vec_none       = 32'h0000_0000;

   typedef enum logic [2:0] {
      op_mov_gpr = 3'd0,
      op_mov_seg = 3'd1,
      op_lea     = 3'd2,
      op_push    = 3'd3,
      op_jmp_rel = 3'd4,
      op_jmp_far = 3'd5,
      op_int     = 3'd6
   } agen_op_e;

   // mem_size: 0 is 2 bytes, 1 is 4 bytes, 2 is 8 bytes
   typedef struct packed {
      agen_op_e    opcode;
      logic [2:0]  dest;
      logic [2:0]  base_id;
      logic [2:0]  index_id;
      logic [2:0]  seg_id;
      logic        base_en;
      logic        index_en;
      logic        disp_en;
      logic [1:0]  scale;
      logic [1:0]  mem_size;
      logic [31:0] eip;
      logic [31:0] imm;
      logic [15:0] sel;
      logic        nmi_en;
      logic        pf_en;
      logic        gp_en;
   } agen_uop_t;

   typedef struct packed {
      agen_op_e    opcode;
      logic [2:0]  dest;
      logic        base_en;
      logic        index_en;
      logic        disp_en;
      logic [1:0]  scale;
      logic [1:0]  mem_size;
      logic [31:0] eip;
      logic [31:0] imm;
      logic [15:0] sel;
      logic        nmi_en;
      logic        pf_en;
      logic        gp_en;
      logic [31:0] base_data;
      logic [31:0] index_data;
      logic [31:0] sp_data;
      logic [15:0] seg_data;
   } agen_issue_t;

   typedef struct packed {
      agen_op_e    opcode;
      logic        gpr_we;
      logic        seg_we;
      logic [2:0]  dest;
      logic [31:0] value;
      logic [31:0] lin_addr;
      logic [31:0] next_eip;
      logic [15:0] next_cs;
   } agen_result_t;

   // Register target of one opcode
   typedef struct packed {
      logic       gpr_we;
      logic       seg_we;
      logic [2:0] id;
   } agen_wr_t;

   function automatic agen_wr_t agen_wr_target(agen_op_e op, logic [2:0] dest);
      agen_wr_t wr;
      wr = '{gpr_we: 1'b0, seg_we: 1'b0, id: dest};
      case (op)
         op_mov_gpr, op_lea: wr.gpr_we = 1'b1;
         op_mov_seg:         wr.seg_we = 1'b1;
         op_push: begin
            wr.gpr_we = 1'b1;
            wr.id     = sp_id;
         end
         default: ;
      endcase
      return wr;
   endfunction

endpackage

//--- src/agen_regfile.sv
`timescale 1ns/1ns

module agen_regfile (
   input  logic        clk,
   input  logic        arst_n,
   input  logic [2:0]  gpr_ra0,
   input  logic [2:0]  gpr_ra1,
   input  logic [2:0]  gpr_ra2,
   output logic [31:0] gpr_rd0,
   output logic [31:0] gpr_rd1,
   output logic [31:0] gpr_rd2,
   input  logic [2:0]  seg_ra,
   output logic [15:0] seg_rd,
   input  logic        gpr_we,
   input  logic        seg_we,
   input  logic [2:0]  wa,
   input  logic [31:0] wd
);
   import agen_pkg::*;

   logic [31:0] gpr [num_regs];
   logic [15:0] seg [num_regs];

   assign gpr_rd0 = gpr[gpr_ra0];
   assign gpr_rd1 = gpr[gpr_ra1];
   assign gpr_rd2 = gpr[gpr_ra2];
   assign seg_rd  = seg[seg_ra];

   // Segment writes take the low half of the write data
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < num_regs; i++) begin
            gpr[i] <= '0;
            seg[i] <= '0;
         end
      end else begin
         if (gpr_we) begin
            gpr[wa] <= wd;
         end
         if (seg_we) begin
            seg[wa] <= wd[15:0];
         end
      end
   end

endmodule

//--- src/agen_result.sv
`timescale 1ns/1ns

module agen_result (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   exe_valid,
   input  agen_pkg::agen_result_t exe,
   output logic                   res_valid,
   output agen_pkg::agen_result_t res,
   output logic                   gpr_we,
   output logic                   seg_we,
   output logic [2:0]             wa,
   output logic [31:0]            wd
);
   import agen_pkg::*;

   // Enables are cleared here too, the scoreboard in decode reads them
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         res_valid <= 1'b0;
         res       <= '0;
      end else begin
         res_valid <= exe_valid;
         res       <= exe;
      end
   end

   // Retire into the register file at the edge ending the result cycle
   assign gpr_we = res_valid && res.gpr_we;
   assign seg_we = res_valid && res.seg_we;
   assign wa     = res.dest;
   assign wd     = res.value;

endmodule

//--- src/agen_top.sv
`timescale 1ns/1ns

module agen_top (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   wb_cyc,
   input  logic                   wb_stb,
   input  logic                   wb_we,
   input  agen_pkg::agen_uop_t    wb_dat_w,
   output logic                   wb_ack,
   output logic                   res_valid,
   output agen_pkg::agen_result_t res
);
   import agen_pkg::*;

   logic [2:0]   gpr_ra0;
   logic [2:0]   gpr_ra1;
   logic [2:0]   gpr_ra2;
   logic [31:0]  gpr_rd0;
   logic [31:0]  gpr_rd1;
   logic [31:0]  gpr_rd2;
   logic [2:0]   seg_ra;
   logic [15:0]  seg_rd;
   logic         gpr_we;
   logic         seg_we;
   logic [2:0]   wa;
   logic [31:0]  wd;
   logic         issue_valid;
   agen_issue_t  issue;
   logic         exe_valid;
   agen_result_t exe;

   agen_regfile regfile_i (
      .clk     (clk),
      .arst_n  (arst_n),
      .gpr_ra0 (gpr_ra0),
      .gpr_ra1 (gpr_ra1),
      .gpr_ra2 (gpr_ra2),
      .gpr_rd0 (gpr_rd0),
      .gpr_rd1 (gpr_rd1),
      .gpr_rd2 (gpr_rd2),
      .seg_ra  (seg_ra),
      .seg_rd  (seg_rd),
      .gpr_we  (gpr_we),
      .seg_we  (seg_we),
      .wa      (wa),
      .wd      (wd)
   );

   // Execute and result registers double as scoreboard entries
   agen_decode decode_i (
      .clk           (clk),
      .arst_n        (arst_n),
      .wb_cyc        (wb_cyc),
      .wb_stb        (wb_stb),
      .wb_we         (wb_we),
      .wb_dat_w      (wb_dat_w),
      .wb_ack        (wb_ack),
      .gpr_ra0       (gpr_ra0),
      .gpr_ra1       (gpr_ra1),
      .gpr_ra2       (gpr_ra2),
      .gpr_rd0       (gpr_rd0),
      .gpr_rd1       (gpr_rd1),
      .gpr_rd2       (gpr_rd2),
      .seg_ra        (seg_ra),
      .seg_rd        (seg_rd),
      .exe_busy_dest (exe),
      .res_busy_dest (res),
      .issue_valid   (issue_valid),
      .issue         (issue)
   );

   agen_execute execute_i (
      .clk         (clk),
      .arst_n      (arst_n),
      .issue_valid (issue_valid),
      .issue       (issue),
      .exe_valid   (exe_valid),
      .exe         (exe)
   );

   agen_result result_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .exe_valid (exe_valid),
      .exe       (exe),
      .res_valid (res_valid),
      .res       (res),
      .gpr_we    (gpr_we),
      .seg_we    (seg_we),
      .wa        (wa),
      .wd        (wd)
   );

endmodule

//--- testbench/agen_assertions.sv
`timescale 1ns/1ns

module agen_assertions (
   input logic clk,
   input logic arst_n,
   input logic wb_cyc,
   input logic wb_stb,
   input logic wb_we,
   input logic wb_ack,
   input logic issue_valid,
   input logic exe_valid,
   input logic res_valid
);

   // Ack answers a live write cycle
   ack_needs_request: assert property (@(posedge clk) disable iff (!arst_n)
      $rose(wb_ack) |-> $past(wb_cyc && wb_stb && wb_we))
      else $error("ack rose without cyc, stb and we");

   ack_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
      wb_ack |=> !wb_ack)
      else $error("ack held for more than one cycle");

   // Decode, execute, result
   result_after_ack: assert property (@(posedge clk) disable iff (!arst_n)
      wb_ack |-> ##2 res_valid)
      else $error("res_valid did not follow ack two cycles later");

   quiet_in_reset: assert property (@(posedge clk)
      !arst_n |=> !wb_ack && !issue_valid && !exe_valid && !res_valid)
      else $error("handshake or stage valid high during reset");

endmodule

bind agen_top agen_assertions assertions_i (.*);

//--- testbench/agen_checker.sv
`timescale 1ns/1ns

module agen_checker (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   res_valid,
   input  agen_pkg::agen_result_t res,
   output int                     seen_cnt,
   output int                     pass_cnt,
   output int                     fail_cnt
);
   import agen_pkg::*;

   agen_result_t expected[$];

   task automatic load_expected();
      int           fd;
      int           code;
      int           n;
      string        line;
      logic [31:0]  f [20];
      agen_op_e     op;
      agen_result_t e;
      fd = $fopen("testbench/agen_tests.txt", "r");
      if (fd == 0) begin
         $display("Checker could not open testbench/agen_tests.txt");
         return;
      end
      while (!$feof(fd)) begin
         code = $fgets(line, fd);
         if (code > 1 && line[0] != "#") begin
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                        f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19]);
            if (n == 20) begin
               e          = '0;
               op         = agen_op_e'(f[0][2:0]);
               e.opcode   = op;
               // MOV and LEA write their destination, PUSH writes the stack pointer
               e.gpr_we   = (op == op_mov_gpr) || (op == op_lea) || (op == op_push);
               e.seg_we   = (op == op_mov_seg);
               e.dest     = (op == op_push) ? sp_id : f[1][2:0];
               e.value    = f[16];
               e.lin_addr = f[17];
               e.next_eip = f[18];
               e.next_cs  = f[19][15:0];
               expected.push_back(e);
            end
         end
      end
      $fclose(fd);
   endtask

   // Results must come back in issue order, one per line of the file
   task automatic compare_result();
      agen_result_t e;
      string        got_s;
      string        exp_s;
      if (seen_cnt >= expected.size()) begin
         $display("Extra result at %0t ns after all %0d tests were answered",
                  $time, expected.size());
         fail_cnt++;
      end else begin
         e = expected[seen_cnt];
         if (res.opcode == e.opcode && res.gpr_we == e.gpr_we && res.seg_we == e.seg_we &&
             res.dest == e.dest && res.value == e.value && res.lin_addr == e.lin_addr &&
             res.next_eip == e.next_eip && res.next_cs == e.next_cs) begin
            pass_cnt++;
            $display("PASS test %0d opcode %0d", seen_cnt + 1, e.opcode);
         end else begin
            fail_cnt++;
            got_s = $sformatf("op %0d we %b%b dst %0d val %h lin %h eip %h cs %h",
                              res.opcode, res.gpr_we, res.seg_we, res.dest,
                              res.value, res.lin_addr, res.next_eip, res.next_cs);
            exp_s = $sformatf("op %0d we %b%b dst %0d val %h lin %h eip %h cs %h",
                              e.opcode, e.gpr_we, e.seg_we, e.dest,
                              e.value, e.lin_addr, e.next_eip, e.next_cs);
            $display("FAIL %0t ns: test %0d got %s, expected %s",
                     $time, seen_cnt + 1, got_s, exp_s);
         end
      end
      seen_cnt++;
   endtask

   initial begin
      seen_cnt = 0;
      pass_cnt = 0;
      fail_cnt = 0;
      load_expected();
   end

   // Result port is stable at the falling edge
   always @(negedge clk) begin
      if (arst_n && res_valid) begin
         compare_result();
      end
   end

endmodule

//--- testbench/agen_tests.txt
# op dst bas idx seg be ie de sc sz eip imm sel nmi pf gp value lin_addr next_eip next_cs
# op 0 mov_gpr 1 mov_seg 2 lea 3 push 4 jmp_rel 5 jmp_far 6 int, sz 0 1 2 is 2 4 8 bytes
0 1 0 0 0 0 0 0 0 0 00000000 00001000 0000 0 0 0 00001000 00000000 00000000 0000
0 2 0 0 0 0 0 0 0 0 00000000 00000020 0000 0 0 0 00000020 00000000 00000000 0000
1 3 0 0 0 0 0 0 0 0 00000000 abcd0040 0000 0 0 0 00000040 00000000 00000000 0000
2 0 1 2 3 1 1 1 2 0 00000000 00000010 0000 0 0 0 00001090 00401090 00000000 0000
2 0 1 2 3 0 1 1 1 0 00000000 00000010 0000 0 0 0 00000050 00400050 00000000 0000
2 0 1 2 3 1 0 1 3 0 00000000 00000010 0000 0 0 0 00001010 00401010 00000000 0000
2 0 1 2 3 1 1 0 0 0 00000000 00000010 0000 0 0 0 00001020 00401020 00000000 0000
2 5 1 2 0 1 1 1 3 0 00000000 00000010 0000 0 0 0 00001110 00001110 00000000 0000
0 4 0 0 0 0 0 0 0 0 00000000 00002000 0000 0 0 0 00002000 00000000 00000000 0000
3 4 0 0 3 0 0 0 0 0 00000000 00000000 0000 0 0 0 00001ffe 00401ffe 00000000 0000
3 4 0 0 3 0 0 0 0 1 00000000 00000000 0000 0 0 0 00001ffa 00401ffa 00000000 0000
3 4 0 0 3 0 0 0 0 2 00000000 00000000 0000 0 0 0 00001ff2 00401ff2 00000000 0000
4 0 0 0 0 0 0 0 0 0 00001000 00000234 0000 0 0 0 00000000 00000000 00001234 0000
4 0 0 0 0 0 0 0 0 0 00008000 ffffff00 0000 0 0 0 00000000 00000000 00007f00 0000
5 0 0 0 0 0 0 0 0 0 00000500 00010000 0008 0 0 0 00000000 00000000 00010000 0008
6 0 0 0 0 0 0 0 0 0 00000000 00000000 0000 1 1 1 00000010 00000010 00000000 0000
6 0 0 0 0 0 0 0 0 0 00000000 00000000 0000 0 1 1 00000070 00000070 00000000 0000
6 0 0 0 0 0 0 0 0 0 00000000 00000000 0000 0 0 1 00000068 00000068 00000000 0000
6 0 0 0 0 0 0 0 0 0 00000000 00000000 0000 0 0 0 00000000 00000000 00000000 0000
6 0 0 0 0 0 0 0 0 0 00000000 00000000 0000 1 0 0 00000010 00000010 00000000 0000

//--- testbench/tb_agen.sv
`timescale 1ns/1ns

module tb_agen;
   import agen_pkg::*;

   localparam int ack_limit = 100;
   localparam int res_limit = 100;

   logic         clk = 1'b0;
   logic         arst_n;
   logic         wb_cyc;
   logic         wb_stb;
   logic         wb_we;
   agen_uop_t    wb_dat_w;
   logic         wb_ack;
   logic         res_valid;
   agen_result_t res;
   int           seen_cnt;
   int           pass_cnt;
   int           fail_cnt;
   agen_uop_t    uops[$];
   logic         timed_out;
   logic         bad_file;

   always #5 clk = ~clk;

   agen_top dut_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .wb_cyc    (wb_cyc),
      .wb_stb    (wb_stb),
      .wb_we     (wb_we),
      .wb_dat_w  (wb_dat_w),
      .wb_ack    (wb_ack),
      .res_valid (res_valid),
      .res       (res)
   );

   agen_checker checker_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .res_valid (res_valid),
      .res       (res),
      .seen_cnt  (seen_cnt),
      .pass_cnt  (pass_cnt),
      .fail_cnt  (fail_cnt)
   );

   // Only the uop columns matter here, the checker takes the rest
   task automatic load_uops();
      int          fd;
      int          code;
      int          n;
      string       line;
      logic [31:0] f [20];
      agen_uop_t   u;
      fd = $fopen("testbench/agen_tests.txt", "r");
      if (fd == 0) begin
         $display("Could not open testbench/agen_tests.txt");
         bad_file = 1'b1;
         return;
      end
      while (!$feof(fd)) begin
         code = $fgets(line, fd);
         if (code > 1 && line[0] != "#") begin
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                        f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19]);
            if (n == 20) begin
               u          = '0;
               u.opcode   = agen_op_e'(f[0][2:0]);
               u.dest     = f[1][2:0];
               u.base_id  = f[2][2:0];
               u.index_id = f[3][2:0];
               u.seg_id   = f[4][2:0];
               u.base_en  = f[5][0];
               u.index_en = f[6][0];
               u.disp_en  = f[7][0];
               u.scale    = f[8][1:0];
               u.mem_size = f[9][1:0];
               u.eip      = f[10];
               u.imm      = f[11];
               u.sel      = f[12][15:0];
               u.nmi_en   = f[13][0];
               u.pf_en    = f[14][0];
               u.gp_en    = f[15][0];
               uops.push_back(u);
            end else begin
               $display("Malformed line in test file: %s", line);
               bad_file = 1'b1;
            end
         end
      end
      $fclose(fd);
   endtask

   // Called on a falling edge, returns on the falling edge that sees ack
   task automatic send_uop(input agen_uop_t u, input int idx);
      int cycles;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = 1'b1;
      wb_dat_w = u;
      cycles   = 0;
      do begin
         @(negedge clk);
         cycles++;
      end while (!wb_ack && cycles < ack_limit);
      if (!wb_ack) begin
         $display("Timeout: test %0d was not acknowledged within %0d cycles", idx, cycles);
         timed_out = 1'b1;
      end
   endtask

   task automatic wait_results();
      int cycles;
      cycles = 0;
      while (seen_cnt < uops.size() && cycles < res_limit) begin
         @(negedge clk);
         cycles++;
      end
      if (seen_cnt < uops.size()) begin
         $display("Timeout: only %0d of %0d results arrived", seen_cnt, uops.size());
         timed_out = 1'b1;
      end
   endtask

   initial begin
      arst_n    = 1'b0;
      wb_cyc    = 1'b0;
      wb_stb    = 1'b0;
      wb_we     = 1'b0;
      wb_dat_w  = '0;
      timed_out = 1'b0;
      bad_file  = 1'b0;
      load_uops();
      repeat (8) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      @(negedge clk);
      // Back to back, each uop goes out on the edge that saw the previous ack
      for (int i = 0; i < uops.size() && !timed_out; i++) begin
         send_uop(uops[i], i + 1);
      end
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
      wait_results();
      // A few idle cycles to catch duplicated results
      repeat (4) @(negedge clk);
      $display("Tests: %0d expected, %0d seen, %0d passed, %0d failed",
               uops.size(), seen_cnt, pass_cnt, fail_cnt);
      if (!timed_out && !bad_file && uops.size() > 0 && fail_cnt == 0 &&
          seen_cnt == uops.size()) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule
